// File: smc_lite.f
+incdir+source
source/smc_lite_pkg.sv
source/smc_access_if.sv
source/smc_access_seq.sv
source/smc_addr_lite.sv
source/smc_lite.sv
bench/smc_lite_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := smc_lite_tb
FILELIST := smc_lite.f
OBJDIR   := obj_dir
LOG      := sim.log
FAIL_MSG := RESULT: FAIL
PASS_MSG := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP), fail if the log reports failure"
	@echo "  clean  remove build output and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/smc_lite_tb.sv
// Testbench for the static memory controller, directed and random requests
// Every external access is checked against a reference of the address rules
`include "smc_lite_defs.svh"

module smc_lite_tb;

   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed
   {
      logic [31:0] addr;
      logic [3:0]  n_be;
      logic        write;
   } access_t;                              // One external access

   logic        sys_clk19;
   logic        n_sys_reset19;
   logic        req;
   logic        ack;
   logic [31:0] addr;
   logic [1:0]  xfer_size;
   logic [1:0]  bus_size;
   logic        cs;
   logic        write;
   logic [31:0] smc_addr;
   logic [3:0]  smc_n_be;
   logic        smc_n_cs;
   logic        smc_n_we;

   access_t     exp_q[$];                   // From the reference
   access_t     act_q[$];                   // From the monitor
   string       cur_test = "reset";
   logic        cur_cs = 1'b0;              // cs of the request in flight
   logic        prev_n_cs = 1'b1;
   logic        low_we = 1'b1;              // smc_n_we at start of access
   int          low_cnt = 0;
   int          mismatch_errors = 0;
   int          protocol_errors = 0;
   int          timeout_errors = 0;
   event        compare_ev;

   smc_lite i_smc_lite
   (
      .sys_clk19     (sys_clk19),
      .n_sys_reset19 (n_sys_reset19),
      .req           (req),
      .ack           (ack),
      .addr          (addr),
      .xfer_size     (xfer_size),
      .bus_size      (bus_size),
      .cs            (cs),
      .write         (write),
      .smc_addr      (smc_addr),
      .smc_n_be      (smc_n_be),
      .smc_n_cs      (smc_n_cs),
      .smc_n_we      (smc_n_we)
   );

   initial
   begin
      sys_clk19 = 1'b0;
      forever #50 sys_clk19 = ~sys_clk19;   // 100 ns period
   end

   // ------------------------------------------------------------------------
   // Reference, expected accesses of one request
   // ------------------------------------------------------------------------
   function automatic void build_expected(input logic [31:0] a, input logic [1:0] xs,
                                          input logic [1:0] bs, input logic c, input logic w);
      int         n;
      logic [1:0] lo [4];
      logic [3:0] be;
      access_t    e;
      n     = 1;
      lo[0] = a[1:0];                       // Byte transfer keeps its own bits
      if (xs == `SMC_SIZE_32 && bs == `SMC_SIZE_32)
         lo[0] = 2'b00;
      else if (xs == `SMC_SIZE_32 && bs == `SMC_SIZE_16)
      begin
         n     = 2;
         lo[0] = 2'b10;                     // Upper half first
         lo[1] = 2'b00;
      end
      else if (xs == `SMC_SIZE_32 && bs == `SMC_SIZE_8)
      begin
         n     = 4;
         lo[0] = 2'b11;
         lo[1] = 2'b10;
         lo[2] = 2'b01;
         lo[3] = 2'b00;
      end
      else if (xs == `SMC_SIZE_16 && bs == `SMC_SIZE_8)
      begin
         n     = 2;
         lo[0] = {a[1], 1'b1};
         lo[1] = {a[1], 1'b0};
      end
      else if (xs == `SMC_SIZE_16)
         lo[0] = {a[1], 1'b0};              // Halfword aligned
      // Active-low lanes, little-endian
      if (bs == `SMC_SIZE_8)
         be = 4'b1110;
      else if (bs == `SMC_SIZE_16)
         be = (xs != `SMC_SIZE_8) ? 4'b1100 : (a[0] ? 4'b1101 : 4'b1110);
      else if (xs == `SMC_SIZE_32)
         be = 4'b0000;
      else if (xs == `SMC_SIZE_16)
         be = a[1] ? 4'b0011 : 4'b1100;
      else
         case (a[1:0])
            2'd0    : be = 4'b1110;
            2'd1    : be = 4'b1101;
            2'd2    : be = 4'b1011;
            default : be = 4'b0111;
         endcase
      for (int i = 0; i < n; i++)
      begin
         e.addr  = {a[31:2], lo[i]};
         e.n_be  = be;
         e.write = w;
         if (c)                             // No access without chip select
            exp_q.push_back(e);
      end
   endfunction

   task automatic check_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         mismatch_errors++;
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic finish_run();
      $display("Errors: mismatch %0d, protocol %0d, timeout %0d",
               mismatch_errors, protocol_errors, timeout_errors);
      if (mismatch_errors + protocol_errors + timeout_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   endtask

   // Wait for ack to reach a level, bounded
   task automatic wait_for_ack(input logic level);
      logic seen;
      seen = 1'b0;
      for (int cnt = 0; cnt < 64 && !seen; cnt++)
      begin
         @(posedge sys_clk19);
         seen = (ack === level);
      end
      if (!seen)
      begin
         timeout_errors++;
         $display("ERROR: ack never went to %0d in test %s", level, cur_test);
         finish_run();
      end
   endtask

   // Four-phase handshake, hold = extra cycles req stays up after ack
   task automatic run_request(input logic [31:0] a, input logic [1:0] xs,
                              input logic [1:0] bs, input logic c, input logic w,
                              input int hold);
      cur_test = $sformatf("xs%0d_bs%0d_a%h_cs%0d_we%0d", xs, bs, a, c, w);
      cur_cs   = c;
      build_expected(a, xs, bs, c, w);
      @(posedge sys_clk19);
      addr      <= a;
      xfer_size <= xs;
      bus_size  <= bs;
      cs        <= c;
      write     <= w;
      req       <= 1'b1;
      wait_for_ack(1'b1);
      -> compare_ev;                        // All accesses are in by now
      repeat (hold)
      begin
         @(posedge sys_clk19);
         assert (ack)
         else
         begin
            protocol_errors++;
            $display("ERROR: ack dropped while req still high in test %s", cur_test);
         end
      end
      req <= 1'b0;
      wait_for_ack(1'b0);
   endtask

   // ------------------------------------------------------------------------
   // Monitor, one entry per falling edge of smc_n_cs
   // ------------------------------------------------------------------------
   always @(posedge sys_clk19)
   begin
      access_t e;
      if (n_sys_reset19)
      begin
         if (!smc_n_cs)
         begin
            if (prev_n_cs)                  // Access starts
            begin
               e.addr  = smc_addr;
               e.n_be  = smc_n_be;
               e.write = !smc_n_we;
               act_q.push_back(e);
               low_cnt = 0;
               low_we  = smc_n_we;
            end
            low_cnt++;
            assert (smc_n_we == low_we)
            else
            begin
               protocol_errors++;
               $display("ERROR: smc_n_we changed during an access in test %s", cur_test);
            end
            assert (!ack)
            else
            begin
               protocol_errors++;
               $display("ERROR: access active while ack high in test %s", cur_test);
            end
         end
         else
         begin
            if (!prev_n_cs)                 // Access just ended
               check_equal({cur_test, "_cs_width"}, `SMC_WAIT_STATES + 1, low_cnt);
            check_equal({cur_test, "_idle_be"}, 32'hF, {28'd0, smc_n_be});
            assert (smc_n_we || !cur_cs)
            else
            begin
               protocol_errors++;
               $display("ERROR: smc_n_we low outside an access in test %s", cur_test);
            end
         end
      end
      prev_n_cs = smc_n_cs;
   end

   // Compare process, runs once per acknowledged request
   initial
   begin
      access_t exp_e;
      access_t act_e;
      forever
      begin
         @(compare_ev);
         assert (act_q.size() == exp_q.size())
         else
         begin
            protocol_errors++;
            $display("ERROR: test %s made %0d accesses before ack, %0d expected",
                     cur_test, act_q.size(), exp_q.size());
         end
         while (exp_q.size() > 0 && act_q.size() > 0)
         begin
            exp_e = exp_q.pop_front();
            act_e = act_q.pop_front();
            assert (act_e == exp_e)
            else
            begin
               mismatch_errors++;
               $display("MISMATCH %s expected %h/%b/%b actual %h/%b/%b", cur_test,
                        exp_e.addr, exp_e.n_be, exp_e.write,
                        act_e.addr, act_e.n_be, act_e.write);
            end
         end
         exp_q.delete();
         act_q.delete();
      end
   end

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   initial
   begin
      logic [31:0] a;
      void'($urandom(32'ha5685295));
      n_sys_reset19 = 1'b0;
      req           = 1'b0;
      addr          = '0;
      xfer_size     = `SMC_SIZE_8;
      bus_size      = `SMC_SIZE_8;
      cs            = 1'b0;
      write         = 1'b0;
      repeat (4) @(posedge sys_clk19);
      n_sys_reset19 <= 1'b1;
      repeat (2) @(posedge sys_clk19);
      check_equal("reset_n_cs", 32'd1, {31'd0, smc_n_cs});   // Idle outputs
      check_equal("reset_n_we", 32'd1, {31'd0, smc_n_we});
      check_equal("reset_n_be", 32'hF, {28'd0, smc_n_be});
      check_equal("reset_ack", 32'd0, {31'd0, ack});
      check_equal("reset_addr", 32'd0, smc_addr);
      // All nine size pairs with every low address
      for (int x = 0; x < 3; x++)
         for (int b = 0; b < 3; b++)
            for (int lo = 0; lo < 4; lo++)
            begin
               a      = $urandom();
               a[1:0] = 2'(lo);
               run_request(a, 2'(x), 2'(b), 1'b1, a[2], int'($urandom_range(3)));
            end
      // Random traffic
      repeat (200)
      begin
         repeat ($urandom_range(3)) @(posedge sys_clk19);   // Idle gap
         run_request($urandom(), 2'($urandom_range(2)), 2'($urandom_range(2)),
                     ($urandom_range(3) != 0), 1'($urandom_range(1)),
                     int'($urandom_range(4)));
      end
      repeat (2) @(posedge sys_clk19);
      finish_run();
   end

endmodule

// File: source/smc_lite.sv
// Top level of the static memory controller with plain host and memory ports
// Sequencer feeds the address stage through smc_access_if
module smc_lite
(
   input  logic                  sys_clk19,
   input  logic                  n_sys_reset19,
   // Host request, four-phase handshake
   input  logic                  req,
   output logic                  ack,
   input  smc_lite_pkg::addr_t   addr,
   input  smc_lite_pkg::size_t   xfer_size,
   input  smc_lite_pkg::size_t   bus_size,
   input  logic                  cs,
   input  logic                  write,
   // External memory
   output smc_lite_pkg::addr_t   smc_addr,
   output smc_lite_pkg::be_n_t   smc_n_be,
   output logic                  smc_n_cs,
   output logic                  smc_n_we
);

   smc_access_if i_acc ();       // Stage one to stage two

   smc_access_seq i_smc_access_seq
   (
      .sys_clk19     (sys_clk19),
      .n_sys_reset19 (n_sys_reset19),
      .req           (req),
      .ack           (ack),
      .addr          (addr),
      .xfer_size     (xfer_size),
      .bus_size      (bus_size),
      .cs            (cs),
      .write         (write),
      .smc_n_we      (smc_n_we),
      .acc           (i_acc.seq)
   );

   smc_addr_lite i_smc_addr_lite
   (
      .sys_clk19     (sys_clk19),
      .n_sys_reset19 (n_sys_reset19),
      .acc           (i_acc.addr),
      .smc_addr      (smc_addr),
      .smc_n_be      (smc_n_be),
      .smc_n_cs      (smc_n_cs)
   );

endmodule

// File: source/smc_addr_lite.sv
// Stage two of the controller: registered external address, chip select
// and byte enables, low address bits stepped per access, little-endian
`include "smc_lite_defs.svh"

module smc_addr_lite
(
   input  logic                  sys_clk19,
   input  logic                  n_sys_reset19,
   smc_access_if.addr            acc,
   output smc_lite_pkg::addr_t   smc_addr,
   output smc_lite_pkg::be_n_t   smc_n_be,
   output logic                  smc_n_cs
);

   logic                  r_cs;        // Stored chip select
   logic                  v_cs;        // Validated chip select
   logic [1:0]            r_addr;      // Stored low address bits
   logic [1:0]            v_addr;      // Validated low address bits
   logic [1:0]            first_low;   // Low bits of the first access
   logic [1:0]            next_low;    // Low bits of the following access
   smc_lite_pkg::be_n_t   n_be;        // Unregistered byte enables

   // -----------------------------------------------------------------------
   // Chip select and low address store
   // -----------------------------------------------------------------------
   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
      begin
         r_cs   <= 1'b0;
         r_addr <= 2'd0;
      end
      else if (acc.valid_access)
      begin
         r_cs   <= acc.cs;
         r_addr <= acc.req_addr[1:0];
      end
   end

   assign v_cs   = acc.valid_access ? acc.cs : r_cs;
   assign v_addr = acc.valid_access ? acc.req_addr[1:0] : r_addr;

   // -----------------------------------------------------------------------
   // Address stepping, highest lane first
   // -----------------------------------------------------------------------
   always_comb
   begin
      case ({acc.xfer_size, acc.bus_size})
         {`SMC_SIZE_32, `SMC_SIZE_32} : first_low = 2'b00;
         {`SMC_SIZE_32, `SMC_SIZE_16} : first_low = 2'b10;               // Upper half
         {`SMC_SIZE_32, `SMC_SIZE_8}  : first_low = 2'b11;               // Top byte
         {`SMC_SIZE_16, `SMC_SIZE_32},
         {`SMC_SIZE_16, `SMC_SIZE_16} : first_low = {acc.req_addr[1], 1'b0};
         {`SMC_SIZE_16, `SMC_SIZE_8}  : first_low = {acc.req_addr[1], 1'b1};
         default                      : first_low = acc.req_addr[1:0];  // Byte transfer
      endcase
   end

   // num_access here still counts the access that follows
   always_comb
   begin
      case ({acc.xfer_size, acc.bus_size})
         {`SMC_SIZE_32, `SMC_SIZE_16} : next_low = 2'b00;
         {`SMC_SIZE_32, `SMC_SIZE_8}  : next_low = acc.num_access - 2'd1;  // 10, 01, 00
         {`SMC_SIZE_16, `SMC_SIZE_8}  : next_low = {r_addr[1], 1'b0};
         default                      : next_low = smc_addr[1:0];        // Single access
      endcase
   end

   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
         smc_addr <= '0;
      else if (acc.valid_access)
         smc_addr <= {acc.req_addr[31:2], first_low};
      else if (acc.done && (acc.num_access != 2'd0))
         smc_addr[1:0] <= next_low;                    // Upper bits held
   end

   // -----------------------------------------------------------------------
   // Byte enable decode
   // -----------------------------------------------------------------------
   always_comb
   begin
      n_be = 4'b1111;
      if (v_cs)
      begin
         case ({acc.xfer_size, acc.bus_size})
            {`SMC_SIZE_32, `SMC_SIZE_32} : n_be = 4'b0000;   // Full word
            {`SMC_SIZE_32, `SMC_SIZE_16},
            {`SMC_SIZE_16, `SMC_SIZE_16} : n_be = 4'b1100;   // Low halfword lanes
            {`SMC_SIZE_32, `SMC_SIZE_8},
            {`SMC_SIZE_16, `SMC_SIZE_8},
            {`SMC_SIZE_8,  `SMC_SIZE_8}  : n_be = 4'b1110;   // Lane 0 only
            {`SMC_SIZE_16, `SMC_SIZE_32} :
               n_be = v_addr[1] ? 4'b0011 : 4'b1100;
            {`SMC_SIZE_8,  `SMC_SIZE_16} :
               n_be = v_addr[0] ? 4'b1101 : 4'b1110;         // Odd byte on lane 1
            {`SMC_SIZE_8,  `SMC_SIZE_32} :
               n_be = ~(4'b0001 << v_addr);                  // Lane from low bits
            default                      : n_be = 4'b1111;   // Reserved size code
         endcase
      end
   end

   // -----------------------------------------------------------------------
   // Registered outputs, one cycle behind rw_next
   // -----------------------------------------------------------------------
   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
      begin
         smc_n_cs <= 1'b1;
         smc_n_be <= 4'hF;
      end
      else if (acc.rw_next)
      begin
         smc_n_cs <= !v_cs;
         smc_n_be <= n_be;
      end
      else
      begin
         smc_n_cs <= 1'b1;                 // Gap between accesses
         smc_n_be <= 4'hF;
      end
   end

   // An active chip select always has at least one lane
   a_cs_has_lane : assert property (@(posedge sys_clk19) disable iff (!n_sys_reset19)
      !smc_n_cs |-> (smc_n_be != 4'hF));

   // Halfword bank keeps the upper lanes off
   a_bus16_lanes : assert property (@(posedge sys_clk19) disable iff (!n_sys_reset19)
      ($past(acc.bus_size) == `SMC_SIZE_16) |-> (&smc_n_be[3:2]));

endmodule

// File: source/smc_access_seq.sv
// Stage one of the controller: host req/ack handshake and access FSM
// Splits each request into 1, 2 or 4 external accesses
`include "smc_lite_defs.svh"

module smc_access_seq
(
   input  logic                  sys_clk19,
   input  logic                  n_sys_reset19,
   input  logic                  req,
   output logic                  ack,
   input  smc_lite_pkg::addr_t   addr,
   input  smc_lite_pkg::size_t   xfer_size,
   input  smc_lite_pkg::size_t   bus_size,
   input  logic                  cs,
   input  logic                  write,
   output logic                  smc_n_we,
   smc_access_if.seq             acc
);

   smc_lite_pkg::smc_state_t     state;           // Current FSM state
   smc_lite_pkg::smc_state_t     next_state;
   smc_lite_pkg::size_t          r_xfer_size;     // Captured sizes
   smc_lite_pkg::size_t          r_bus_size;
   logic                         r_write;         // Captured write flag
   logic                         v_write;         // Validated write flag
   logic                         valid_access;
   logic                         done;
   logic                         rw_next;
   logic                         last_wait;       // Final wait cycle
   smc_lite_pkg::access_cnt_t    r_num_access;    // Accesses still to run
   smc_lite_pkg::access_cnt_t    new_num_access;  // Decoded from size pair
   smc_lite_pkg::wait_cnt_t      wait_cnt;

   // -----------------------------------------------------------------------
   // Request capture and access count
   // -----------------------------------------------------------------------
   assign valid_access = (state == smc_lite_pkg::SMC_IDLE) && req;

   always_comb
   begin
      case ({xfer_size, bus_size})
         {`SMC_SIZE_32, `SMC_SIZE_8}  : new_num_access = 2'd3;   // Four bytes
         {`SMC_SIZE_32, `SMC_SIZE_16} : new_num_access = 2'd1;   // Two halfwords
         {`SMC_SIZE_16, `SMC_SIZE_8}  : new_num_access = 2'd1;   // Two bytes
         default                      : new_num_access = 2'd0;   // Single access
      endcase
   end

   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
      begin
         r_xfer_size <= `SMC_SIZE_8;
         r_bus_size  <= `SMC_SIZE_8;
         r_write     <= 1'b0;
      end
      else if (valid_access)
      begin
         r_xfer_size <= xfer_size;
         r_bus_size  <= bus_size;
         r_write     <= write;
      end
   end

   // Live inputs during valid_access, stored copy afterwards
   assign v_write = valid_access ? write : r_write;

   // -----------------------------------------------------------------------
   // Access FSM
   // -----------------------------------------------------------------------
   assign last_wait = (wait_cnt == smc_lite_pkg::wait_cnt_t'(`SMC_WAIT_STATES));
   assign done      = (state == smc_lite_pkg::SMC_RW) && last_wait;
   assign rw_next   = (next_state == smc_lite_pkg::SMC_RW);

   always_comb
   begin
      next_state = state;
      case (state)
         smc_lite_pkg::SMC_IDLE :
            if (valid_access)
               next_state = smc_lite_pkg::SMC_RW;
         smc_lite_pkg::SMC_RW :
            if (last_wait)                   // Access ends this cycle
               next_state = (r_num_access == 2'd0) ? smc_lite_pkg::SMC_ACK
                                                   : smc_lite_pkg::SMC_TURN;
         smc_lite_pkg::SMC_TURN :
            next_state = smc_lite_pkg::SMC_RW;
         smc_lite_pkg::SMC_ACK :
            if (!req)                        // Host finished the handshake
               next_state = smc_lite_pkg::SMC_IDLE;
         default :
            next_state = smc_lite_pkg::SMC_IDLE;
      endcase
   end

   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
      begin
         state        <= smc_lite_pkg::SMC_IDLE;
         wait_cnt     <= '0;
         r_num_access <= '0;
         ack          <= 1'b0;
         smc_n_we     <= 1'b1;
      end
      else
      begin
         state <= next_state;
         if ((state == smc_lite_pkg::SMC_RW) && !last_wait)
            wait_cnt <= wait_cnt + 3'd1;          // Count wait states
         else
            wait_cnt <= '0;
         if (valid_access)
            r_num_access <= new_num_access;
         else if (done && (r_num_access != 2'd0))
            r_num_access <= r_num_access - 2'd1;  // One access retired
         ack      <= (next_state == smc_lite_pkg::SMC_ACK);
         smc_n_we <= !(rw_next && v_write);       // Aligned with smc_n_cs
      end
   end

   // -----------------------------------------------------------------------
   // Interface drive
   // -----------------------------------------------------------------------
   assign acc.valid_access = valid_access;
   assign acc.req_addr     = addr;
   assign acc.cs           = cs;
   assign acc.xfer_size    = valid_access ? xfer_size : r_xfer_size;
   assign acc.bus_size     = valid_access ? bus_size : r_bus_size;
   assign acc.num_access   = valid_access ? new_num_access : r_num_access;
   assign acc.done         = done;
   assign acc.rw_next      = rw_next;

   // No new request while the previous one is still acknowledged
   a_ack_excl_valid : assert property (@(posedge sys_clk19) disable iff (!n_sys_reset19)
      !(ack && valid_access));

   // done only in SMC_RW, and the FSM leaves SMC_RW right after it
   a_done_in_rw : assert property (@(posedge sys_clk19) disable iff (!n_sys_reset19)
      done |-> (state == smc_lite_pkg::SMC_RW) ##1 (state != smc_lite_pkg::SMC_RW));

endmodule

// File: source/smc_access_if.sv
// Per-access control from the sequencer to the address stage
// Sequencer drives through seq, address stage reads through addr
interface smc_access_if;

   logic                        valid_access;  // Start of request, one cycle
   smc_lite_pkg::addr_t         req_addr;      // Host address, valid with valid_access
   logic                        cs;            // Host chip select, same timing
   smc_lite_pkg::size_t         xfer_size;     // Held for the whole request
   smc_lite_pkg::size_t         bus_size;      // Held for the whole request
   smc_lite_pkg::access_cnt_t   num_access;    // Accesses left after this one
   logic                        done;          // Last cycle of an access
   logic                        rw_next;       // Next state is SMC_RW

   modport seq
   (
      output valid_access, req_addr, cs, xfer_size, bus_size,
      output num_access, done, rw_next
   );

   modport addr
   (
      input  valid_access, req_addr, cs, xfer_size, bus_size,
      input  num_access, done, rw_next
   );

endinterface

// File: source/smc_lite_pkg.sv
// Types shared by the static memory controller stages and their interface
// Referenced by scoped name only
`include "smc_lite_defs.svh"

package smc_lite_pkg;

   // -----------------------------------------------------------------------
   // Width types
   // -----------------------------------------------------------------------
   typedef logic [31:0] addr_t;        // Byte address
   typedef logic [1:0]  size_t;        // Size code, see defs header
   typedef logic [3:0]  be_n_t;        // Byte enables, active low
   typedef logic [1:0]  access_cnt_t;  // Accesses left after the current one
   typedef logic [2:0]  wait_cnt_t;    // Wait-state counter

   // -----------------------------------------------------------------------
   // Sequencer FSM
   // -----------------------------------------------------------------------
   typedef enum logic [1:0]
   {
      SMC_IDLE = `SMC_ST_IDLE,
      SMC_RW   = `SMC_ST_RW,
      SMC_TURN = `SMC_ST_TURN,
      SMC_ACK  = `SMC_ST_ACK
   } smc_state_t;

endpackage

// File: source/smc_lite_defs.svh
// Shared constants of the static memory controller
// Included by the package and by both pipeline stages
`ifndef SMC_DEFS_SVH
`define SMC_DEFS_SVH

// --------------------------------------------------------------------------
// Size codes, same encoding for transfer size and bank bus width
// --------------------------------------------------------------------------
`define SMC_SIZE_8        2'd0       // Byte
`define SMC_SIZE_16       2'd1       // Halfword
`define SMC_SIZE_32       2'd2       // Word, code 3 reserved

// --------------------------------------------------------------------------
// Sequencer state encodings
// --------------------------------------------------------------------------
`define SMC_ST_IDLE       2'd0       // Waiting for req
`define SMC_ST_RW         2'd1       // External access, chip select phase
`define SMC_ST_TURN       2'd2       // Gap between accesses
`define SMC_ST_ACK        2'd3       // Holding ack until req drops

// Extra cycles per external access, 0 to 7
`define SMC_WAIT_STATES   1

`endif
